//--- src/rv_csr_pkg.sv
// Shared widths, CSR addresses, privilege modes and constants for the rv_csr design
package rv_csr_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN    = 32;
    localparam int CAUSE_W = 4;
    localparam int IRQ_W   = 12;

    // ------------------------------
    // CSR access bus addresses
    // ------------------------------
    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // Only user and machine are implemented
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_e;

    // ------------------------------
    // Field positions and masks
    // ------------------------------
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // MSI, MTI and MEI
    localparam logic [IRQ_W-1:0] MIE_MASK = 12'h888;
    localparam logic [IRQ_W-1:0] MIP_MASK = 12'h888;

    // ------------------------------
    // Identity constants
    // ------------------------------
    // MXL=1, U and I extensions
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_0100;
    localparam logic [XLEN-1:0] VENDOR_ID  = '0;
    localparam logic [XLEN-1:0] ARCH_ID    = '0;
    localparam logic [XLEN-1:0] IMPL_ID    = '0;

endpackage

//--- src/priv_ctrl.sv
// Privilege mode FSM and mstatus fields, updated by trap entry, mret and CSR writes
`timescale 1ns/1ps

module priv_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           trap_valid,
    input  logic                           mret,
    input  logic                           write_en,
    input  logic [11:0]                    write_addr,
    input  logic [rv_csr_pkg::XLEN-1:0]    write_data,
    output rv_csr_pkg::priv_mode_e         priv,
    output logic [rv_csr_pkg::XLEN-1:0]    mstatus_value
);

    rv_csr_pkg::priv_mode_e priv_next;
    rv_csr_pkg::priv_mode_e status_mpp;
    rv_csr_pkg::priv_mode_e status_mpp_next;
    logic                   status_mie;
    logic                   status_mie_next;
    logic                   status_mpie;
    logic                   status_mpie_next;
    logic                   status_write;

    assign status_write = write_en && (write_addr == rv_csr_pkg::CSR_MSTATUS);

    // Trap beats mret, mret beats a CSR write
    always_comb begin
        priv_next        = priv;
        status_mie_next  = status_mie;
        status_mpie_next = status_mpie;
        status_mpp_next  = status_mpp;
        if (trap_valid) begin
            priv_next        = rv_csr_pkg::PRIV_MACHINE;
            status_mpie_next = status_mie;
            status_mie_next  = 1'b0;
            status_mpp_next  = priv;
        end else if (mret) begin
            priv_next        = status_mpp;
            status_mie_next  = status_mpie;
            status_mpp_next  = rv_csr_pkg::PRIV_USER;
        end else if (status_write) begin
            status_mie_next  = write_data[rv_csr_pkg::MSTATUS_MIE_BIT];
            status_mpie_next = write_data[rv_csr_pkg::MSTATUS_MPIE_BIT];
            // Unsupported modes fall back to user
            status_mpp_next  = (write_data[rv_csr_pkg::MSTATUS_MPP_LSB +: 2] == 2'b11)
                               ? rv_csr_pkg::PRIV_MACHINE : rv_csr_pkg::PRIV_USER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv        <= rv_csr_pkg::PRIV_MACHINE;
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            status_mpp  <= rv_csr_pkg::PRIV_USER;
        end else begin
            priv        <= priv_next;
            status_mie  <= status_mie_next;
            status_mpie <= status_mpie_next;
            status_mpp  <= status_mpp_next;
        end
    end

    // Unimplemented fields read as zero
    always_comb begin
        mstatus_value = '0;
        mstatus_value[rv_csr_pkg::MSTATUS_MIE_BIT]      = status_mie;
        mstatus_value[rv_csr_pkg::MSTATUS_MPIE_BIT]     = status_mpie;
        mstatus_value[rv_csr_pkg::MSTATUS_MPP_LSB +: 2] = status_mpp;
    end

endmodule

//--- src/cycle_counter.sv
// 64-bit mcycle counter that runs every clock and takes CSR writes to either half
`timescale 1ns/1ps

module cycle_counter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        write_en,
    input  logic [11:0]                 write_addr,
    input  logic [rv_csr_pkg::XLEN-1:0] write_data,
    output logic [63:0]                 cycle_count
);

    logic write_low;
    logic write_high;

    assign write_low  = write_en && (write_addr == rv_csr_pkg::CSR_MCYCLE);
    assign write_high = write_en && (write_addr == rv_csr_pkg::CSR_MCYCLEH);

    // A written half holds for one cycle instead of counting
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
        end else if (write_low) begin
            cycle_count <= {cycle_count[63:32], write_data};
        end else if (write_high) begin
            cycle_count <= {write_data, cycle_count[31:0]};
        end else begin
            cycle_count <= cycle_count + 64'd1;
        end
    end

endmodule

//--- src/trap_regs.sv
// mepc, mcause and mtval, loaded on trap entry or by CSR writes from the core
`timescale 1ns/1ps

module trap_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           trap_valid,
    input  logic                           trap_interrupt,
    input  logic [rv_csr_pkg::CAUSE_W-1:0] trap_code,
    input  logic [rv_csr_pkg::XLEN-1:0]    trap_value,
    input  logic [rv_csr_pkg::XLEN-1:0]    trap_pc,
    input  logic                           write_en,
    input  logic [11:0]                    write_addr,
    input  logic [rv_csr_pkg::XLEN-1:0]    write_data,
    output logic [rv_csr_pkg::XLEN-1:0]    mepc,
    output logic [rv_csr_pkg::XLEN-1:0]    mcause_value,
    output logic [rv_csr_pkg::XLEN-1:0]    mtval
);

    logic                           cause_interrupt;
    logic [rv_csr_pkg::CAUSE_W-1:0] cause_code;

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc            <= '0;
            cause_interrupt <= 1'b0;
            cause_code      <= '0;
            mtval           <= '0;
        end else if (trap_valid) begin
            // Trap capture overrides any CSR write this cycle
            mepc            <= {trap_pc[rv_csr_pkg::XLEN-1:2], 2'b00};
            cause_interrupt <= trap_interrupt;
            cause_code      <= trap_code;
            mtval           <= trap_value;
        end else if (write_en) begin
            case (write_addr)
                rv_csr_pkg::CSR_MEPC: begin
                    mepc <= {write_data[rv_csr_pkg::XLEN-1:2], 2'b00};
                end
                rv_csr_pkg::CSR_MCAUSE: begin
                    cause_interrupt <= write_data[rv_csr_pkg::XLEN-1];
                    cause_code      <= write_data[rv_csr_pkg::CAUSE_W-1:0];
                end
                rv_csr_pkg::CSR_MTVAL: mtval <= write_data;
                default: ;
            endcase
        end
    end

    // Interrupt flag on top, code at the bottom
    assign mcause_value = {cause_interrupt,
                           {(rv_csr_pkg::XLEN-1-rv_csr_pkg::CAUSE_W){1'b0}},
                           cause_code};

endmodule

//--- src/machine_regs.sv
// Machine registers written only by CSR instructions: mtvec, mscratch, mie and mip
`timescale 1ns/1ps

module machine_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         write_en,
    input  logic [11:0]                  write_addr,
    input  logic [rv_csr_pkg::XLEN-1:0]  write_data,
    output logic [rv_csr_pkg::XLEN-1:0]  mtvec,
    output logic [rv_csr_pkg::XLEN-1:0]  mscratch,
    output logic [rv_csr_pkg::IRQ_W-1:0] mie,
    output logic [rv_csr_pkg::IRQ_W-1:0] mip
);

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mscratch <= '0;
            mie      <= '0;
            mip      <= '0;
        end else if (write_en) begin
            case (write_addr)
                rv_csr_pkg::CSR_MTVEC:    mtvec    <= write_data;
                rv_csr_pkg::CSR_MSCRATCH: mscratch <= write_data;
                // Only the machine-level interrupt bits are writable
                rv_csr_pkg::CSR_MIE: begin
                    mie <= write_data[rv_csr_pkg::IRQ_W-1:0] & rv_csr_pkg::MIE_MASK;
                end
                rv_csr_pkg::CSR_MIP: begin
                    mip <= write_data[rv_csr_pkg::IRQ_W-1:0] & rv_csr_pkg::MIP_MASK;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- src/csr_read_mux.sv
// Combinational CSR read decode, returning register state or identity constants
`timescale 1ns/1ps

module csr_read_mux #(
    parameter logic [rv_csr_pkg::XLEN-1:0] HART_ID = '0
) (
    input  logic [11:0]                  read_addr,
    input  logic [rv_csr_pkg::XLEN-1:0]  mstatus_value,
    input  logic [rv_csr_pkg::XLEN-1:0]  mepc,
    input  logic [rv_csr_pkg::XLEN-1:0]  mcause_value,
    input  logic [rv_csr_pkg::XLEN-1:0]  mtval,
    input  logic [rv_csr_pkg::XLEN-1:0]  mtvec,
    input  logic [rv_csr_pkg::XLEN-1:0]  mscratch,
    input  logic [rv_csr_pkg::IRQ_W-1:0] mie,
    input  logic [rv_csr_pkg::IRQ_W-1:0] mip,
    input  logic [63:0]                  cycle_count,
    output logic [rv_csr_pkg::XLEN-1:0]  read_data
);

    localparam int IRQ_PAD = rv_csr_pkg::XLEN - rv_csr_pkg::IRQ_W;

    always_comb begin
        case (read_addr)
            rv_csr_pkg::CSR_MSTATUS:   read_data = mstatus_value;
            rv_csr_pkg::CSR_MIE:       read_data = {{IRQ_PAD{1'b0}}, mie};
            rv_csr_pkg::CSR_MTVEC:     read_data = mtvec;
            rv_csr_pkg::CSR_MSCRATCH:  read_data = mscratch;
            rv_csr_pkg::CSR_MEPC:      read_data = mepc;
            rv_csr_pkg::CSR_MCAUSE:    read_data = mcause_value;
            rv_csr_pkg::CSR_MTVAL:     read_data = mtval;
            rv_csr_pkg::CSR_MIP:       read_data = {{IRQ_PAD{1'b0}}, mip};
            rv_csr_pkg::CSR_MCYCLE:    read_data = cycle_count[31:0];
            rv_csr_pkg::CSR_MCYCLEH:   read_data = cycle_count[63:32];
            // Identity registers
            rv_csr_pkg::CSR_MISA:      read_data = rv_csr_pkg::MISA_VALUE;
            rv_csr_pkg::CSR_MVENDORID: read_data = rv_csr_pkg::VENDOR_ID;
            rv_csr_pkg::CSR_MARCHID:   read_data = rv_csr_pkg::ARCH_ID;
            rv_csr_pkg::CSR_MIMPID:    read_data = rv_csr_pkg::IMPL_ID;
            rv_csr_pkg::CSR_MHARTID:   read_data = HART_ID;
            default:                   read_data = '0;
        endcase
    end

endmodule

//--- src/rv_csr.sv
// Machine-mode CSR file top level, instantiated by the core beside its decode stage
`timescale 1ns/1ps

module rv_csr #(
    parameter logic [rv_csr_pkg::XLEN-1:0] HART_ID = '0
) (
    input  logic                                clk,
    input  logic                                rst,
    // CSR access bus
    input  logic [11:0]                         read_addr,
    output logic [rv_csr_pkg::XLEN-1:0]         read_data,
    input  logic                                write_en,
    input  logic [11:0]                         write_addr,
    input  logic [rv_csr_pkg::XLEN-1:0]         write_data,
    // Trap request and return
    input  logic                                trap_valid,
    input  logic                                trap_interrupt,
    input  logic [rv_csr_pkg::CAUSE_W-1:0]      trap_code,
    input  logic [rv_csr_pkg::XLEN-1:0]         trap_value,
    input  logic [rv_csr_pkg::XLEN-1:0]         trap_pc,
    input  logic                                mret,
    // State seen by the core
    output rv_csr_pkg::priv_mode_e              priv,
    output logic                                status_mie,
    output logic [rv_csr_pkg::XLEN-1:0]         mtvec,
    output logic [rv_csr_pkg::XLEN-1:0]         mepc
);

    logic [rv_csr_pkg::XLEN-1:0]  mstatus_value;
    logic [rv_csr_pkg::XLEN-1:0]  mcause_value;
    logic [rv_csr_pkg::XLEN-1:0]  mtval;
    logic [rv_csr_pkg::XLEN-1:0]  mscratch;
    logic [rv_csr_pkg::IRQ_W-1:0] mie;
    logic [rv_csr_pkg::IRQ_W-1:0] mip;
    logic [63:0]                  cycle_count;

    assign status_mie = mstatus_value[rv_csr_pkg::MSTATUS_MIE_BIT];

    priv_ctrl priv_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .trap_valid    (trap_valid),
        .mret          (mret),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .priv          (priv),
        .mstatus_value (mstatus_value)
    );

    cycle_counter cycle_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .cycle_count (cycle_count)
    );

    trap_regs trap_regs_inst (
        .clk            (clk),
        .rst            (rst),
        .trap_valid     (trap_valid),
        .trap_interrupt (trap_interrupt),
        .trap_code      (trap_code),
        .trap_value     (trap_value),
        .trap_pc        (trap_pc),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .mepc           (mepc),
        .mcause_value   (mcause_value),
        .mtval          (mtval)
    );

    machine_regs machine_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .mtvec      (mtvec),
        .mscratch   (mscratch),
        .mie        (mie),
        .mip        (mip)
    );

    csr_read_mux #(
        .HART_ID (HART_ID)
    ) csr_read_mux_inst (
        .read_addr     (read_addr),
        .mstatus_value (mstatus_value),
        .mepc          (mepc),
        .mcause_value  (mcause_value),
        .mtval         (mtval),
        .mtvec         (mtvec),
        .mscratch      (mscratch),
        .mie           (mie),
        .mip           (mip),
        .cycle_count   (cycle_count),
        .read_data     (read_data)
    );

endmodule

//--- tests/rv_csr_chk.sv
// Concurrent assertions on the privilege FSM, bound into every priv_ctrl instance
`timescale 1ns/1ps

module rv_csr_chk (
    input logic                        clk,
    input logic                        rst,
    input logic                        trap_valid,
    input logic                        mret,
    input rv_csr_pkg::priv_mode_e      priv,
    input logic [rv_csr_pkg::XLEN-1:0] mstatus_value
);

    // Trap entry lands in machine mode with interrupts off
    trap_enters_machine: assert property (
        @(posedge clk) disable iff (rst)
        trap_valid |=> (priv == rv_csr_pkg::PRIV_MACHINE)
                       && !mstatus_value[rv_csr_pkg::MSTATUS_MIE_BIT]
    ) else $error("trap did not enter machine mode with MIE cleared");

    mret_restores_mie: assert property (
        @(posedge clk) disable iff (rst)
        (mret && !trap_valid) |=> mstatus_value[rv_csr_pkg::MSTATUS_MIE_BIT]
                                  == $past(mstatus_value[rv_csr_pkg::MSTATUS_MPIE_BIT])
    ) else $error("mret did not copy MPIE into MIE");

    priv_is_legal: assert property (
        @(posedge clk) disable iff (rst)
        priv inside {rv_csr_pkg::PRIV_USER, rv_csr_pkg::PRIV_MACHINE}
    ) else $error("privilege left the user and machine encodings");

endmodule

bind priv_ctrl rv_csr_chk priv_chk_inst (
    .clk           (clk),
    .rst           (rst),
    .trap_valid    (trap_valid),
    .mret          (mret),
    .priv          (priv),
    .mstatus_value (mstatus_value)
);

//--- tests/rv_csr_tb.sv
// Table-driven testbench for rv_csr; a reference model fills the table, a loop replays it
`timescale 1ns/1ps

module rv_csr_tb;

    localparam logic [31:0] TB_HART_ID = 32'h0000_0005;
    localparam int          CLK_HALF   = 4;
    localparam int          EDGE_LIMIT = 4;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_STATE, OP_TRAP, OP_TRAP_WRITE, OP_MRET, OP_IDLE
    } op_e;

    logic                   clk;
    logic                   rst;
    logic [11:0]            read_addr;
    logic [31:0]            read_data;
    logic                   write_en;
    logic [11:0]            write_addr;
    logic [31:0]            write_data;
    logic                   trap_valid;
    logic                   trap_interrupt;
    logic [3:0]             trap_code;
    logic [31:0]            trap_value;
    logic [31:0]            trap_pc;
    logic                   mret;
    rv_csr_pkg::priv_mode_e priv;
    logic                   status_mie;
    logic [31:0]            mtvec;
    logic [31:0]            mepc;

    // Stimulus table
    string       row_name[$];
    op_e         row_op[$];
    logic [11:0] row_addr[$];
    logic [31:0] row_data[$];
    logic [31:0] row_pc[$];
    logic [31:0] row_exp[$];

    // Reference model state
    logic [1:0]  m_priv;
    logic        m_mie;
    logic        m_mpie;
    logic [1:0]  m_mpp;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [11:0] m_irq_en;
    logic [11:0] m_irq_pend;
    logic [63:0] m_count;
    logic        run_done;
    logic        fail_printed;

    rv_csr #(.HART_ID(TB_HART_ID)) rv_csr_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] model_read(logic [11:0] addr);
        case (addr)
            rv_csr_pkg::CSR_MSTATUS:  return {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
            rv_csr_pkg::CSR_MISA:     return 32'h4010_0100;
            rv_csr_pkg::CSR_MIE:      return {20'b0, m_irq_en};
            rv_csr_pkg::CSR_MTVEC:    return m_mtvec;
            rv_csr_pkg::CSR_MSCRATCH: return m_mscratch;
            rv_csr_pkg::CSR_MEPC:     return m_mepc;
            rv_csr_pkg::CSR_MCAUSE:   return m_mcause;
            rv_csr_pkg::CSR_MTVAL:    return m_mtval;
            rv_csr_pkg::CSR_MIP:      return {20'b0, m_irq_pend};
            rv_csr_pkg::CSR_MCYCLE:   return m_count[31:0];
            rv_csr_pkg::CSR_MCYCLEH:  return m_count[63:32];
            rv_csr_pkg::CSR_MHARTID:  return TB_HART_ID;
            default:                  return 32'h0;
        endcase
    endfunction

    function automatic void model_apply(op_e op, logic [11:0] addr, logic [31:0] data,
                                        logic [31:0] pc);
        logic        wr;
        logic        trap;
        logic        owned;
        logic [11:0] waddr;
        wr    = (op == OP_WRITE) || (op == OP_TRAP_WRITE);
        trap  = (op == OP_TRAP) || (op == OP_TRAP_WRITE);
        waddr = (op == OP_TRAP_WRITE) ? rv_csr_pkg::CSR_MEPC : addr;
        if (wr && waddr == rv_csr_pkg::CSR_MCYCLE) begin
            m_count[31:0] = data;
        end else if (wr && waddr == rv_csr_pkg::CSR_MCYCLEH) begin
            m_count[63:32] = data;
        end else begin
            m_count = m_count + 64'd1;
        end
        if (trap) begin
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mpp    = m_priv;
            m_priv   = 2'b11;
            m_mepc   = pc & 32'hFFFF_FFFC;
            m_mcause = {addr[4], 27'b0, addr[3:0]};
            m_mtval  = data;
        end else if (op == OP_MRET) begin
            m_priv = m_mpp;
            m_mie  = m_mpie;
            m_mpp  = 2'b00;
        end
        // Registers the trap itself writes keep the trap's values
        owned = trap && (waddr inside {rv_csr_pkg::CSR_MSTATUS, rv_csr_pkg::CSR_MEPC,
                                       rv_csr_pkg::CSR_MCAUSE, rv_csr_pkg::CSR_MTVAL});
        if (wr && !owned) begin
            case (waddr)
                rv_csr_pkg::CSR_MSTATUS: begin
                    m_mie  = data[3];
                    m_mpie = data[7];
                    m_mpp  = (data[12:11] == 2'b11) ? 2'b11 : 2'b00;
                end
                rv_csr_pkg::CSR_MIE:      m_irq_en   = data[11:0] & 12'h888;
                rv_csr_pkg::CSR_MIP:      m_irq_pend = data[11:0] & 12'h888;
                rv_csr_pkg::CSR_MTVEC:    m_mtvec    = data;
                rv_csr_pkg::CSR_MSCRATCH: m_mscratch = data;
                rv_csr_pkg::CSR_MEPC:     m_mepc     = data & 32'hFFFF_FFFC;
                rv_csr_pkg::CSR_MCAUSE:   m_mcause   = {data[31], 27'b0, data[3:0]};
                rv_csr_pkg::CSR_MTVAL:    m_mtval    = data;
                default: ;
            endcase
        end
    endfunction

    // Expected value is the state seen during the row, before its own effect
    task automatic add_row(string name, op_e op, logic [11:0] addr, logic [31:0] data,
                           logic [31:0] pc);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_pc.push_back(pc);
        if (op == OP_STATE) begin
            row_exp.push_back({29'b0, m_mie, m_priv});
        end else begin
            row_exp.push_back(model_read(addr));
        end
        model_apply(op, addr, data, pc);
    endtask

    // ------------------------------
    // Table
    // ------------------------------
    task automatic build_table();
        logic [11:0] cause;
        add_row("reset_state", OP_STATE, 12'h0, 32'h0, 32'h0);
        add_row("reset_mstatus", OP_READ, rv_csr_pkg::CSR_MSTATUS, 32'h0, 32'h0);
        add_row("reset_mepc", OP_READ, rv_csr_pkg::CSR_MEPC, 32'h0, 32'h0);
        add_row("reset_mtvec", OP_READ, rv_csr_pkg::CSR_MTVEC, 32'h0, 32'h0);
        add_row("reset_mscratch", OP_READ, rv_csr_pkg::CSR_MSCRATCH, 32'h0, 32'h0);
        add_row("wr_mscratch", OP_WRITE, rv_csr_pkg::CSR_MSCRATCH, $urandom, 32'h0);
        add_row("rd_mscratch", OP_READ, rv_csr_pkg::CSR_MSCRATCH, 32'h0, 32'h0);
        add_row("wr_mtvec", OP_WRITE, rv_csr_pkg::CSR_MTVEC, $urandom, 32'h0);
        add_row("rd_mtvec", OP_READ, rv_csr_pkg::CSR_MTVEC, 32'h0, 32'h0);
        add_row("wr_mie", OP_WRITE, rv_csr_pkg::CSR_MIE, 32'hFFFF_FFFF, 32'h0);
        add_row("rd_mie", OP_READ, rv_csr_pkg::CSR_MIE, 32'h0, 32'h0);
        add_row("wr_mip", OP_WRITE, rv_csr_pkg::CSR_MIP, $urandom, 32'h0);
        add_row("rd_mip", OP_READ, rv_csr_pkg::CSR_MIP, 32'h0, 32'h0);
        add_row("wr_misa", OP_WRITE, rv_csr_pkg::CSR_MISA, $urandom, 32'h0);
        add_row("rd_misa", OP_READ, rv_csr_pkg::CSR_MISA, 32'h0, 32'h0);
        add_row("wr_mhartid", OP_WRITE, rv_csr_pkg::CSR_MHARTID, $urandom, 32'h0);
        add_row("rd_mhartid", OP_READ, rv_csr_pkg::CSR_MHARTID, 32'h0, 32'h0);
        add_row("rd_mvendorid", OP_READ, rv_csr_pkg::CSR_MVENDORID, 32'h0, 32'h0);
        add_row("rd_marchid", OP_READ, rv_csr_pkg::CSR_MARCHID, 32'h0, 32'h0);
        add_row("rd_mimpid", OP_READ, rv_csr_pkg::CSR_MIMPID, 32'h0, 32'h0);
        add_row("rd_unknown", OP_READ, 12'h7C0, 32'h0, 32'h0);
        // MIE on, then MPIE on with MPP user, then return to user
        add_row("wr_mstatus_mie", OP_WRITE, rv_csr_pkg::CSR_MSTATUS, 32'h0000_1808, 32'h0);
        add_row("state_mie_on", OP_STATE, 12'h0, 32'h0, 32'h0);
        add_row("wr_mstatus_mpp", OP_WRITE, rv_csr_pkg::CSR_MSTATUS, 32'h0000_0080, 32'h0);
        add_row("rd_mstatus_mpp", OP_READ, rv_csr_pkg::CSR_MSTATUS, 32'h0, 32'h0);
        add_row("mret_to_user", OP_MRET, 12'h0, 32'h0, 32'h0);
        add_row("state_user", OP_STATE, 12'h0, 32'h0, 32'h0);
        add_row("rd_mstatus_ret", OP_READ, rv_csr_pkg::CSR_MSTATUS, 32'h0, 32'h0);
        // Bit 4 of the cause column is the interrupt flag
        cause = 12'($urandom % 32);
        add_row("trap_random", OP_TRAP, cause, $urandom, $urandom);
        add_row("state_trap", OP_STATE, 12'h0, 32'h0, 32'h0);
        add_row("rd_mepc_trap", OP_READ, rv_csr_pkg::CSR_MEPC, 32'h0, 32'h0);
        add_row("rd_mcause_trap", OP_READ, rv_csr_pkg::CSR_MCAUSE, 32'h0, 32'h0);
        add_row("rd_mtval_trap", OP_READ, rv_csr_pkg::CSR_MTVAL, 32'h0, 32'h0);
        add_row("rd_mstatus_trap", OP_READ, rv_csr_pkg::CSR_MSTATUS, 32'h0, 32'h0);
        add_row("mret_again", OP_MRET, 12'h0, 32'h0, 32'h0);
        add_row("state_user_again", OP_STATE, 12'h0, 32'h0, 32'h0);
        add_row("trap_with_write", OP_TRAP_WRITE, 12'h00B, $urandom, $urandom);
        add_row("rd_mepc_priority", OP_READ, rv_csr_pkg::CSR_MEPC, 32'h0, 32'h0);
        // High counter half goes first so the full value is known
        add_row("wr_mcycleh", OP_WRITE, rv_csr_pkg::CSR_MCYCLEH, $urandom, 32'h0);
        add_row("wr_mcycle", OP_WRITE, rv_csr_pkg::CSR_MCYCLE, $urandom, 32'h0);
        add_row("rd_mcycle_next", OP_READ, rv_csr_pkg::CSR_MCYCLE, 32'h0, 32'h0);
        add_row("rd_mcycleh", OP_READ, rv_csr_pkg::CSR_MCYCLEH, 32'h0, 32'h0);
        for (int i = 0; i < 6; i++) begin
            add_row("idle", OP_IDLE, 12'h0, 32'h0, 32'h0);
        end
        add_row("rd_mcycle_later", OP_READ, rv_csr_pkg::CSR_MCYCLE, 32'h0, 32'h0);
        add_row("rd_mcycleh_later", OP_READ, rv_csr_pkg::CSR_MCYCLEH, 32'h0, 32'h0);
    endtask

    // ------------------------------
    // Drive, wait and compare
    // ------------------------------
    task automatic drive_row(int row);
        write_en   <= 1'b0;
        trap_valid <= 1'b0;
        mret       <= 1'b0;
        case (row_op[row])
            OP_WRITE: begin
                write_en   <= 1'b1;
                write_addr <= row_addr[row];
                write_data <= row_data[row];
            end
            OP_READ: read_addr <= row_addr[row];
            OP_TRAP, OP_TRAP_WRITE: begin
                trap_valid     <= 1'b1;
                trap_interrupt <= row_addr[row][4];
                trap_code      <= row_addr[row][3:0];
                trap_value     <= row_data[row];
                trap_pc        <= row_pc[row];
                if (row_op[row] == OP_TRAP_WRITE) begin
                    write_en   <= 1'b1;
                    write_addr <= rv_csr_pkg::CSR_MEPC;
                    write_data <= row_data[row];
                end
            end
            OP_MRET: mret <= 1'b1;
            default: ;
        endcase
    endtask

    task automatic wait_clk_level(logic level);
        int toggles;
        toggles = 0;
        do begin
            @(clk);
            toggles++;
        end while (clk !== level && toggles < EDGE_LIMIT);
        if (clk !== level) begin
            fail_printed = 1'b1;
            $display("ERRORS FOUND");
            $fatal(1, "clock did not reach the expected level in time");
        end
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
            fail_printed = 1'b1;
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        void'($urandom(32'h54f8));
        rst            <= 1'b1;
        read_addr      <= 12'h0;
        write_en       <= 1'b0;
        write_addr     <= 12'h0;
        write_data     <= 32'h0;
        trap_valid     <= 1'b0;
        trap_interrupt <= 1'b0;
        trap_code      <= 4'h0;
        trap_value     <= 32'h0;
        trap_pc        <= 32'h0;
        mret           <= 1'b0;
        run_done     = 1'b0;
        fail_printed = 1'b0;
        // Model starts from the reset state
        m_priv     = 2'b11;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mpp      = 2'b00;
        m_mepc     = 32'h0;
        m_mcause   = 32'h0;
        m_mtval    = 32'h0;
        m_mtvec    = 32'h0;
        m_mscratch = 32'h0;
        m_irq_en   = 12'h0;
        m_irq_pend = 12'h0;
        m_count    = 64'h0;
        build_table();
        repeat (3) wait_clk_level(1'b1);
        rst <= 1'b0;
        for (int row = 0; row < row_op.size(); row++) begin
            wait_clk_level(1'b1);
            drive_row(row);
            // Sample mid-cycle
            wait_clk_level(1'b0);
            if (row_op[row] == OP_READ) begin
                check_value(row_name[row], row_exp[row], read_data);
                // mtvec and mepc also leave the DUT as ports
                if (row_addr[row] == rv_csr_pkg::CSR_MTVEC) begin
                    check_value({row_name[row], "_port"}, row_exp[row], mtvec);
                end else if (row_addr[row] == rv_csr_pkg::CSR_MEPC) begin
                    check_value({row_name[row], "_port"}, row_exp[row], mepc);
                end
            end else if (row_op[row] == OP_STATE) begin
                check_value(row_name[row], row_exp[row], {29'b0, status_mie, priv});
            end
        end
        run_done = 1'b1;
        $display("NO ERRORS");
        $finish;
    end

    // Run stopped early, as by a failed assertion
    final begin
        if (!run_done && !fail_printed) begin
            $display("ERRORS FOUND");
        end
    end

endmodule

//--- rv_csr.f
src/rv_csr_pkg.sv
src/priv_ctrl.sv
src/cycle_counter.sv
src/trap_regs.sv
src/machine_regs.sv
src/csr_read_mux.sv
src/rv_csr.sv
tests/rv_csr_chk.sv
tests/rv_csr_tb.sv

//--- Makefile
# Verilator build and run of the rv_csr testbench

VERILATOR ?= verilator
TOP       ?= rv_csr_tb
FILELIST  ?= rv_csr.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
